//--- list.f
+incdir+rtl
rtl/rv_types_pkg.sv
rtl/rv_reg_pkg.sv
rtl/rv_rpri.sv
rtl/rv_station_array.sv
rtl/rv_station_regs.sv
rtl/rv_station.sv
verification/rv_station_tb.sv

//--- Bender.yml
package:
  name: rv_station

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_types_pkg.sv
      - rtl/rv_reg_pkg.sv
      - rtl/rv_rpri.sv
      - rtl/rv_station_array.sv
      - rtl/rv_station_regs.sv
      - rtl/rv_station.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/rv_station_tb.sv

//--- verification/rv_station_tb.sv
//##########################################################################
// Testbench for the reservation station issue-select top level
// Clock, reset, random dispatch, wakeup and register traffic
// Cycle-accurate queue model, per-cycle checks and closing report
//##########################################################################

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_station_tb
   import rv_types_pkg::*;
   import rv_reg_pkg::*;
();

   localparam int entries   = `RV_ENTRIES;
   localparam int rdata_w   = `RV_RDATA_W;
   localparam int reset_cyc = 16;
   localparam int order_cyc = 80;
   localparam int rand_cyc  = 600;
   localparam int off_cyc   = 60;
   localparam int thr_cyc   = 200;
   localparam int cnt_cyc   = 100;
   localparam int misc_cyc  = 80;
   // All test phases plus a margin for the waits
   localparam int cycle_limit = reset_cyc + order_cyc + rand_cyc + off_cyc
                              + 2 * thr_cyc + cnt_cyc + misc_cyc + 200;

   logic               clk;
   logic               arst_n;
   logic               disp_valid;
   disp_t              disp;
   logic               wake_valid;
   rtag_t              wake_tag;
   reg_req_t           reg_req;
   logic               full;
   logic               issue_valid;
   issue_t             issue;
   logic [rdata_w-1:0] reg_rdata;

   // Model state with the oldest entry at queue index 0
   rs_entry_t          m_q[$];
   logic               m_iv;
   issue_t             m_issue;
   logic               m_en;
   throttle_t          m_thr;
   throttle_t          m_quiet;
   logic [rdata_w-1:0] m_cnt;

   integer seed;
   int     errors;
   int     checks;
   int     cycle_cnt;
   int     neg_cnt;
   int     last_issue;
   int     gap_t;
   int     lat;
   logic   no_issue;
   itag_t  next_itag;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   rv_station dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .disp_valid (disp_valid),
      .disp       (disp),
      .wake_valid (wake_valid),
      .wake_tag   (wake_tag),
      .reg_req    (reg_req),
      .full       (full),
      .issue_valid(issue_valid),
      .issue      (issue),
      .reg_rdata  (reg_rdata)
   );

   // One model step per rising edge from the inputs driven half a cycle before
   always @(posedge clk or negedge arst_n)
   begin : model_step
      int        g;
      logic      allow;
      throttle_t quiet_eff;
      rs_entry_t e;
      if (!arst_n)
      begin
         m_q.delete();
         m_iv    = 1'b0;
         m_en    = 1'b1;
         m_thr   = '0;
         m_quiet = '0;
         m_cnt   = '0;
      end
      else
      begin
         // The hold counter loads T in the issue_valid cycle and then counts down
         quiet_eff = m_iv ? m_thr : m_quiet;
         allow     = m_en && (quiet_eff == '0);
         // Oldest entry whose stored ready bits are both set
         g = -1;
         for (int i = 0; i < m_q.size(); i++)
         begin
            if ((g < 0) && m_q[i].src0_rdy && m_q[i].src1_rdy)
               g = i;
         end
         // Wakeup reaches the stored sources one edge later than selection
         for (int i = 0; i < m_q.size(); i++)
         begin
            if (wake_valid && (m_q[i].src0 == wake_tag))
               m_q[i].src0_rdy = 1'b1;
            if (wake_valid && (m_q[i].src1 == wake_tag))
               m_q[i].src1_rdy = 1'b1;
         end
         if (reg_req.wr && (reg_req.addr == issue_count))
            m_cnt = '0;
         else if (m_iv)
            m_cnt = m_cnt + 1'b1;
         if (reg_req.wr && (reg_req.addr == ctrl))
         begin
            m_en  = reg_req.wdata[0];
            m_thr = reg_req.wdata[7:4];
         end
         m_quiet = (quiet_eff == '0) ? '0 : quiet_eff - 1'b1;
         m_iv    = allow && (g >= 0);
         if (m_iv)
         begin
            m_issue.itag = m_q[g].itag;
            m_issue.src0 = m_q[g].src0;
            m_issue.src1 = m_q[g].src1;
            m_q.delete(g);
         end
         // A new entry joins at the young end and sees the same broadcast
         if (disp_valid)
         begin
            e.valid    = 1'b1;
            e.itag     = disp.itag;
            e.src0     = disp.src0;
            e.src1     = disp.src1;
            e.src0_rdy = disp.src0_rdy | (wake_valid && (disp.src0 == wake_tag));
            e.src1_rdy = disp.src1_rdy | (wake_valid && (disp.src1 == wake_tag));
            m_q.push_back(e);
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
   endtask

   // Compares every output with the model at the falling edge
   task automatic compare_outputs();
      logic [rdata_w-1:0] exp_rd;
      exp_rd = '0;
      case (reg_req.addr)
         ctrl:
         begin
            exp_rd[0]   = m_en;
            exp_rd[7:4] = m_thr;
         end
         status:      exp_rd = rdata_w'(m_q.size());
         issue_count: exp_rd = m_cnt;
         default:     exp_rd = '0;
      endcase
      checks++;
      if (issue_valid !== m_iv)
         report_mismatch("issue_valid", m_iv, issue_valid);
      if (m_iv && (issue.itag !== m_issue.itag))
         report_mismatch("issue.itag", m_issue.itag, issue.itag);
      if (m_iv && (issue.src0 !== m_issue.src0))
         report_mismatch("issue.src0", m_issue.src0, issue.src0);
      if (m_iv && (issue.src1 !== m_issue.src1))
         report_mismatch("issue.src1", m_issue.src1, issue.src1);
      if (full !== (m_q.size() == entries))
         report_mismatch("full", m_q.size() == entries, full);
      if (reg_rdata !== exp_rd)
         report_mismatch("reg_rdata", exp_rd, reg_rdata);
      if (issue_valid === 1'b1)
      begin
         if (no_issue)
         begin
            errors++;
            $display("ERROR at %0t ns: an instruction issued while issue was disabled", $time);
         end
         // Consecutive issues must sit at least T+1 cycles apart
         if ((gap_t >= 0) && (last_issue >= 0) && (neg_cnt - last_issue < gap_t + 1))
         begin
            errors++;
            $display("ERROR at %0t ns: issues only %0d cycles apart with throttle %0d",
                     $time, neg_cnt - last_issue, gap_t);
         end
         last_issue = neg_cnt;
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      neg_cnt++;
      compare_outputs();
   endtask

   task automatic drive_idle();
      disp_valid    = 1'b0;
      disp          = '0;
      wake_valid    = 1'b0;
      wake_tag      = '0;
      reg_req.wr    = 1'b0;
      reg_req.addr  = ctrl;
      reg_req.wdata = '0;
   endtask

   // Probabilities are out of 16 and tags come from 0..7 so wakeups often match
   task automatic drive_random(input int p_disp, input int p_rdy, input int p_wake,
                               input logic clr_cnt);
      disp_valid    = (($random(seed) & 15) < p_disp) && (m_q.size() < entries);
      disp.itag     = next_itag;
      disp.src0     = rtag_t'($random(seed) & 7);
      disp.src0_rdy = (($random(seed) & 15) < p_rdy);
      disp.src1     = rtag_t'($random(seed) & 7);
      disp.src1_rdy = (($random(seed) & 15) < p_rdy);
      if (disp_valid)
         next_itag = next_itag + 1'b1;
      wake_valid    = (($random(seed) & 15) < p_wake);
      wake_tag      = rtag_t'($random(seed) & 7);
      reg_req.wr    = 1'b0;
      reg_req.wdata = '0;
      reg_req.addr  = reg_addr_e'($random(seed) & 3);
      if (clr_cnt && (($random(seed) & 31) == 0))
      begin
         reg_req.wr   = 1'b1;
         reg_req.addr = issue_count;
      end
   endtask

   task automatic run_random(input int cycles, input int p_disp, input int p_rdy,
                             input int p_wake, input logic clr_cnt);
      repeat (cycles)
      begin
         next_cycle();
         drive_random(p_disp, p_rdy, p_wake, clr_cnt);
      end
   endtask

   task automatic write_reg(input reg_addr_e addr, input logic [rdata_w-1:0] data);
      next_cycle();
      drive_idle();
      reg_req.wr    = 1'b1;
      reg_req.addr  = addr;
      reg_req.wdata = data;
   endtask

   initial
   begin
      seed       = 47;
      errors     = 0;
      checks     = 0;
      neg_cnt    = 0;
      last_issue = -1;
      gap_t      = -1;
      no_issue   = 1'b0;
      next_itag  = '0;
      arst_n     = 1'b0;
      drive_idle();
      repeat (reset_cyc) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Reset leaves the outputs idle with enable set and no throttle
      if (issue_valid !== 1'b0)
         report_mismatch("issue_valid", 0, issue_valid);
      if (full !== 1'b0)
         report_mismatch("full", 0, full);
      if (reg_rdata !== 16'h0001)
         report_mismatch("reg_rdata(ctrl)", 16'h0001, reg_rdata);
      reg_req.addr = status;
      #1;
      if (reg_rdata !== '0)
         report_mismatch("reg_rdata(status)", 0, reg_rdata);

      // A lone ready dispatch into the empty queue issues two edges later
      next_cycle();
      drive_idle();
      disp_valid    = 1'b1;
      disp.itag     = next_itag;
      disp.src0     = rtag_t'(3);
      disp.src0_rdy = 1'b1;
      disp.src1     = rtag_t'(5);
      disp.src1_rdy = 1'b1;
      next_itag     = next_itag + 1'b1;
      next_cycle();
      drive_idle();
      lat = 1;
      while ((issue_valid !== 1'b1) && (lat < 10))
      begin
         next_cycle();
         lat++;
      end
      if (issue_valid !== 1'b1)
      begin
         errors++;
         $display("ERROR at %0t ns: no issue within 10 cycles of a ready dispatch", $time);
      end
      else if (lat != 2)
         report_mismatch("dispatch to issue_valid edges", 2, lat);

      // All sources ready so issue follows dispatch order
      run_random(order_cyc, 10, 16, 0, 1'b0);
      // Random readiness with wakeups and occasional counter clears
      run_random(rand_cyc, 12, 6, 5, 1'b1);

      // A grant from the cycle of the write may still appear once
      write_reg(ctrl, 16'h0000);
      next_cycle();
      drive_idle();
      no_issue = 1'b1;
      run_random(off_cyc, 10, 8, 4, 1'b0);
      no_issue = 1'b0;

      write_reg(ctrl, 16'h0031);
      last_issue = -1;
      gap_t      = 3;
      run_random(thr_cyc, 12, 10, 5, 1'b0);
      write_reg(ctrl, 16'h0071);
      last_issue = -1;
      gap_t      = 7;
      run_random(thr_cyc, 12, 10, 5, 1'b0);
      write_reg(ctrl, 16'h0001);
      gap_t = -1;

      // Clear the issue counter then read it back after more traffic
      write_reg(issue_count, 16'h0000);
      run_random(cnt_cyc, 12, 10, 5, 1'b0);
      next_cycle();
      drive_idle();
      reg_req.addr = issue_count;
      #1;
      if (reg_rdata !== m_cnt)
         report_mismatch("reg_rdata(issue_count)", m_cnt, reg_rdata);

      // Drain whatever can still issue
      run_random(30, 0, 16, 8, 1'b0);
      next_cycle();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Watchdog on the total number of clock cycles
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Run stopped after %0d cycles before the tests completed", cycle_cnt);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- rtl/rv_station.sv
//##########################################################################
// Reservation station issue-select top level
// Entry array, reverse prioritizer and control register block
//##########################################################################

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_station
   import rv_types_pkg::*;
   import rv_reg_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   disp_valid,
   input  disp_t                  disp,
   input  logic                   wake_valid,
   input  rtag_t                  wake_tag,
   input  reg_req_t               reg_req,
   output logic                   full,
   output logic                   issue_valid,
   output issue_t                 issue,
   output logic [`RV_RDATA_W-1:0] reg_rdata
);

   entry_vec_t req_vec;
   entry_vec_t grant_vec;
   occ_t       occupancy;
   logic       issue_allow;

   // Storage, wakeup and collapse
   rv_station_array u_array (
      .clk        (clk),
      .arst_n     (arst_n),
      .disp_valid (disp_valid),
      .disp       (disp),
      .wake_valid (wake_valid),
      .wake_tag   (wake_tag),
      .issue_allow(issue_allow),
      .grant_vec  (grant_vec),
      .req_vec    (req_vec),
      .full       (full),
      .occupancy  (occupancy),
      .issue_valid(issue_valid),
      .issue      (issue)
   );

   // The oldest requesting entry sits at the highest index
   rv_rpri #(.size(`RV_ENTRIES)) u_rpri (
      .cond(req_vec),
      .pri (grant_vec)
   );

   rv_station_regs u_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .reg_req    (reg_req),
      .reg_rdata  (reg_rdata),
      .occupancy  (occupancy),
      .issue_valid(issue_valid),
      .issue_allow(issue_allow)
   );

endmodule

//--- rtl/rv_station_regs.sv
//##########################################################################
// Station control and status registers
// Issue enable and throttle hold counter driving issue_allow
// Occupancy read-back and issued-instruction counter
//##########################################################################

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_station_regs
   import rv_types_pkg::*;
   import rv_reg_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  reg_req_t               reg_req,
   output logic [`RV_RDATA_W-1:0] reg_rdata,
   input  occ_t                   occupancy,
   input  logic                   issue_valid,
   output logic                   issue_allow
);

   logic                   enable_q;
   throttle_t              throttle_q;
   throttle_t              hold_q;
   logic [`RV_RDATA_W-1:0] issue_cnt_q;
   logic                   ctrl_wr;
   logic                   cnt_wr;

   assign ctrl_wr = reg_req.wr && (reg_req.addr == ctrl);
   assign cnt_wr  = reg_req.wr && (reg_req.addr == issue_count);

   // The issue_valid cycle already blocks the next grant
   // so the hold counter only has to cover the remaining T-1 cycles
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         enable_q    <= 1'b1;
         throttle_q  <= '0;
         hold_q      <= '0;
         issue_cnt_q <= '0;
      end
      else
      begin
         if (ctrl_wr)
         begin
            enable_q   <= reg_req.wdata[0];
            throttle_q <= reg_req.wdata[7:4];
         end
         if (issue_valid)
            hold_q <= (throttle_q == '0) ? '0 : throttle_q - 1'b1;
         else if (hold_q != '0)
            hold_q <= hold_q - 1'b1;
         // A write clears the counter and takes priority over a concurrent issue
         if (cnt_wr)
            issue_cnt_q <= '0;
         else if (issue_valid)
            issue_cnt_q <= issue_cnt_q + 1'b1;
      end
   end

   // With interval T this stays low for T cycles after each issue
   assign issue_allow = enable_q && (hold_q == '0) && !(issue_valid && (throttle_q != '0));

   // Reads are combinational from the address, ctrl mirrors its write layout
   always_comb
   begin
      reg_rdata = '0;
      case (reg_req.addr)
         ctrl:
         begin
            reg_rdata[0]   = enable_q;
            reg_rdata[7:4] = throttle_q;
         end
         status:      reg_rdata[$bits(occ_t)-1:0] = occupancy;
         issue_count: reg_rdata = issue_cnt_q;
         default:     reg_rdata = '0;
      endcase
   end

   // A test never runs long enough to overflow the issue counter
   a_cnt_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
      (issue_valid && !cnt_wr) |-> (issue_cnt_q != '1));

endmodule

//--- rtl/rv_station_array.sv
//##########################################################################
// Reservation station entry array
// Dispatch write, wakeup tag match with dispatch bypass, ready vector
// Issue register and age-ordered collapse toward the old end
//##########################################################################

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_station_array
   import rv_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       disp_valid,
   input  disp_t      disp,
   input  logic       wake_valid,
   input  rtag_t      wake_tag,
   input  logic       issue_allow,
   input  entry_vec_t grant_vec,
   output entry_vec_t req_vec,
   output logic       full,
   output occ_t       occupancy,
   output logic       issue_valid,
   output issue_t     issue
);

   localparam int entries = `RV_ENTRIES;

   // Valid entries always sit packed at the top indices, oldest first
   rs_entry_t  ent_q [entries];
   rs_entry_t  woke  [entries];
   rs_entry_t  ent_d [entries];
   rs_entry_t  disp_ent;
   entry_vec_t ready_vec;
   entry_vec_t shift_vec;
   logic       granted;
   occ_t       occ_q;
   occ_t       occ_kept;
   occ_t       occ_d;
   logic       full_q;
   logic       issue_valid_q;
   issue_t     issue_q;
   issue_t     issue_d;

   // Broadcast tag compare against every stored source
   // The ready vector itself is built from the registered bits only
   always_comb
   begin
      for (int i = 0; i < entries; i++)
      begin
         woke[i] = ent_q[i];
         if (wake_valid && ent_q[i].valid && (ent_q[i].src0 == wake_tag))
            woke[i].src0_rdy = 1'b1;
         if (wake_valid && ent_q[i].valid && (ent_q[i].src1 == wake_tag))
            woke[i].src1_rdy = 1'b1;
         ready_vec[i] = ent_q[i].valid & ent_q[i].src0_rdy & ent_q[i].src1_rdy;
      end
   end

   // The dispatched sources see the same broadcast so a wakeup is not lost
   always_comb
   begin
      disp_ent.valid    = 1'b1;
      disp_ent.itag     = disp.itag;
      disp_ent.src0     = disp.src0;
      disp_ent.src1     = disp.src1;
      disp_ent.src0_rdy = disp.src0_rdy | (wake_valid && (disp.src0 == wake_tag));
      disp_ent.src1_rdy = disp.src1_rdy | (wake_valid && (disp.src1 == wake_tag));
   end

   assign req_vec = ready_vec & {entries{issue_allow}};
   assign granted = |grant_vec;

   // shift_vec marks the granted slot and every younger slot below it
   always_comb
   begin
      logic above;
      above = 1'b0;
      for (int i = entries - 1; i >= 0; i--)
      begin
         above        = above | grant_vec[i];
         shift_vec[i] = above;
      end
   end

   // Younger entries move up one slot over the granted one
   // A new dispatch lands just below the youngest surviving entry
   always_comb
   begin
      occ_kept = occ_q - occ_t'(granted);
      occ_d    = occ_kept + occ_t'(disp_valid);
      ent_d[0] = shift_vec[0] ? rs_entry_t'('0) : woke[0];
      for (int i = 1; i < entries; i++)
         ent_d[i] = shift_vec[i] ? woke[i-1] : woke[i];
      for (int i = 0; i < entries; i++)
      begin
         if (disp_valid && (i == entries - 1 - int'(occ_kept)))
            ent_d[i] = disp_ent;
      end
   end

   // The grant is one-hot so the OR of masked fields picks one entry
   always_comb
   begin
      issue_d = '0;
      for (int i = 0; i < entries; i++)
      begin
         if (grant_vec[i])
         begin
            issue_d.itag = ent_q[i].itag;
            issue_d.src0 = ent_q[i].src0;
            issue_d.src1 = ent_q[i].src1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < entries; i++)
            ent_q[i] <= '0;
         occ_q         <= '0;
         full_q        <= 1'b0;
         issue_valid_q <= 1'b0;
      end
      else
      begin
         ent_q         <= ent_d;
         occ_q         <= occ_d;
         full_q        <= (occ_d == occ_t'(entries));
         issue_valid_q <= granted;
      end
   end

   // Issue payload is only meaningful while issue_valid is high
   always_ff @(posedge clk)
   begin
      if (granted)
         issue_q <= issue_d;
   end

   assign full        = full_q;
   assign occupancy   = occ_q;
   assign issue_valid = issue_valid_q;
   assign issue       = issue_q;

   // The dispatcher has to respect the registered full level
   a_no_disp_full: assert property (@(posedge clk) disable iff (!arst_n)
      disp_valid |-> !full_q);

   // The prioritizer must never hand back more than one grant
   a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(grant_vec));

   // A grant may only land on a stored entry with both sources ready
   a_grant_ready: assert property (@(posedge clk) disable iff (!arst_n)
      (grant_vec & ~ready_vec) == '0);

endmodule

//--- rtl/rv_rpri.sv
//##########################################################################
// Reverse prioritizer
// Keeps only the highest-index set bit of the request vector
// Log-depth OR tree with alternating polarity, widths 1 to 32
//##########################################################################

`timescale 1ns/1ps

module rv_rpri #(
   parameter int size = 32
) (
   input  logic [size-1:0] cond,
   output logic [size-1:0] pri
);

   // Five doubling levels reach 32 bits which is the widest supported vector
   localparam int levels = 5;

   // Level 0 is the request vector itself
   // After level k each bit summarizes the 2**k requests starting at its own index
   // Odd levels hold the inverted OR and even levels the true OR
   wire [levels:0][size-1:0] lvl;

   assign lvl[0] = cond;

   for (genvar k = 1; k <= levels; k++)
   begin : g_level
      localparam int stride = 1 << (k - 1);

      for (genvar i = 0; i < size; i++)
      begin : g_bit
         if (i + stride >= size)
         begin : g_edge
            // Nothing above to merge so the bit only flips polarity
            assign lvl[k][i] = ~lvl[k-1][i];
         end
         else if (k % 2 == 1)
         begin : g_nor
            // Previous level is true polarity so a NOR merges the two ranges
            assign lvl[k][i] = ~(lvl[k-1][i] | lvl[k-1][i+stride]);
         end
         else
         begin : g_nand
            // Previous level is inverted and a NAND gives the true OR
            assign lvl[k][i] = ~(lvl[k-1][i] & lvl[k-1][i+stride]);
         end
      end
   end

   // The last level is odd and therefore inverted
   // lvl[levels][i+1] is high when no bit above i requests
   for (genvar i = 0; i < size; i++)
   begin : g_pri
      if (i == size - 1)
      begin : g_top
         // The highest index always wins when it requests
         assign pri[i] = cond[i];
      end
      else
      begin : g_low
         assign pri[i] = cond[i] & lvl[levels][i+1];
      end
   end

endmodule

//--- rtl/rv_reg_pkg.sv
//##########################################################################
// Register bus types of the station control block
// Request layout, register address map, throttle field
//##########################################################################

package rv_reg_pkg;

`include "rv_cfg.svh"

   // Register map
   // Address 3 is unused and reads as zero
   typedef enum logic [`RV_RADDR_W-1:0] {
      ctrl        = 'd0,
      status      = 'd1,
      issue_count = 'd2
   } reg_addr_e;

   // One register access per cycle
   // A read needs no strobe because read data follows addr directly
   typedef struct packed {
      logic                   wr;
      reg_addr_e              addr;
      logic [`RV_RDATA_W-1:0] wdata;
   } reg_req_t;

   // Number of idle cycles forced between two issues
   typedef logic [3:0] throttle_t;

endpackage

//--- rtl/rv_types_pkg.sv
//##########################################################################
// Reservation station types
// Tag vectors, occupancy count, dispatch and issue payloads, entry layout
//##########################################################################

package rv_types_pkg;

`include "rv_cfg.svh"

   // A physical register tag as seen by the wakeup broadcast
   typedef logic [`RV_RTAG_W-1:0] rtag_t;

   // Instruction tag that identifies an instruction at issue
   typedef logic [`RV_ITAG_W-1:0] itag_t;

   // One bit per entry and the top index holds the oldest instruction
   typedef logic [`RV_ENTRIES-1:0] entry_vec_t;

   // Occupancy runs from 0 up to and including the entry count
   typedef logic [$clog2(`RV_ENTRIES+1)-1:0] occ_t;

   // Payload presented by the dispatcher with a disp_valid strobe
   typedef struct packed {
      itag_t itag;
      rtag_t src0;
      logic  src0_rdy;
      rtag_t src1;
      logic  src1_rdy;
   } disp_t;

   // Payload of the instruction that leaves the station
   typedef struct packed {
      itag_t itag;
      rtag_t src0;
      rtag_t src1;
   } issue_t;

   // One stored entry
   // Both ready bits must be set before the entry can request issue
   typedef struct packed {
      logic  valid;
      itag_t itag;
      rtag_t src0;
      rtag_t src1;
      logic  src0_rdy;
      logic  src1_rdy;
   } rs_entry_t;

endpackage

//--- rtl/rv_cfg.svh
//##########################################################################
// Build-time sizes of the reservation station
// Entry count, register and instruction tag widths, register-bus widths
//##########################################################################

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Number of station entries
// The prioritizer levels cover at most 32 entries
`define RV_ENTRIES 8

// Width of a physical register tag carried by each source
`define RV_RTAG_W 6

// Width of the instruction tag that follows an entry to issue
`define RV_ITAG_W 5

// Register bus address width
// Two bits cover ctrl, status and issue_count
`define RV_RADDR_W 2

// Register bus data width
// The issue counter is as wide as a read word
`define RV_RDATA_W 16

`endif
